// File: compile.f
rtl/lcd_timing_pkg.sv
rtl/lcd_cmd_pkg.sv
rtl/lcd_init_sequencer.sv
rtl/lcd_print_sequencer.sv
rtl/lcd_nibble_writer.sv
rtl/lcd_hd44780_top.sv
bench/lcd_hd44780_props.sv
bench/lcd_hd44780_tb.sv

// File: Bender.yml
package:
  name: lcd_hd44780

sources:
  # Packages first, then the stages, then the top level
  - files:
      - rtl/lcd_timing_pkg.sv
      - rtl/lcd_cmd_pkg.sv
      - rtl/lcd_init_sequencer.sv
      - rtl/lcd_print_sequencer.sv
      - rtl/lcd_nibble_writer.sv
      - rtl/lcd_hd44780_top.sv
  - target: test
    files:
      - bench/lcd_hd44780_props.sv
      - bench/lcd_hd44780_tb.sv

// File: bench/lcd_hd44780_tb.sv
// Testbench for the HD44780 controller in 4-bit mode
// Runs the init, then several prints from a random character memory, and checks every write

module lcd_hd44780_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period     = 40;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = 100000;
    localparam int chars_per_line = 20;
    localparam int num_tests      = 4;

    logic                     clk;
    logic                     rst;
    logic                     trg;
    lcd_cmd_pkg::lcd_byte_t   char_data;
    logic                     busy;
    logic                     e;
    logic                     rs;
    lcd_cmd_pkg::lcd_nibble_t db;
    lcd_cmd_pkg::char_addr_t  char_addr;

    // Character memory, 32 slots per line
    lcd_cmd_pkg::lcd_byte_t char_mem [128];
    int seed = 32'hd48d;

    // Display writes as {rs, byte}
    logic [8:0] writes [$];
    logic [8:0] expected [$];

    int   error_count  = 0;
    int   failed_tests = 0;
    logic timed_out    = 1'b0;

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    // A trg delay of 0 marks the init row, which has no trigger
    //                              name               trg   extra  writes
    string test_name   [num_tests] = '{"init", "print_single", "print_retrigger", "print_refill"};
    int    trg_delay   [num_tests] = '{0,      600,            25,                1};
    int    extra_delay [num_tests] = '{0,      0,              4000,              0};
    int    write_count [num_tests] = '{5,      84,             84,                84};

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    lcd_hd44780_top lcd_hd44780_top_i (
        .clk       (clk),
        .rst       (rst),
        .trg       (trg),
        .char_data (char_data),
        .busy      (busy),
        .e         (e),
        .rs        (rs),
        .db        (db),
        .char_addr (char_addr)
    );

    assign char_data = char_mem[char_addr];

    ////////////////////////////////////////
    // Bus monitor
    ////////////////////////////////////////

    logic                     e_seen      = 1'b0;
    logic                     first_write = 1'b1;
    logic                     have_high   = 1'b0;
    lcd_cmd_pkg::lcd_nibble_t high_nib    = '0;

    // Sampled mid-cycle, where e, db and rs have settled
    always @(negedge clk or negedge rst) begin
        if (!rst) begin
            e_seen      = 1'b0;
            first_write = 1'b1;
            have_high   = 1'b0;
        end else begin
            if (e && !e_seen) begin
                if (first_write) begin
                    // Wake-up function set is a lone high nibble
                    writes.push_back({rs, 4'h0, db});
                    first_write = 1'b0;
                end else if (have_high) begin
                    writes.push_back({rs, high_nib, db});
                    have_high = 1'b0;
                end else begin
                    high_nib  = db;
                    have_high = 1'b1;
                end
            end
            e_seen = e;
        end
    end

    ////////////////////////////////////////
    // Tasks
    ////////////////////////////////////////

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 128; i++) begin
            char_mem[i] = lcd_cmd_pkg::lcd_byte_t'($random(seed));
        end
    endtask

    task automatic wait_for_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < timeout_cycles) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (busy !== level) begin
            $display("Timeout: busy did not go to %0d within %0d cycles while %s",
                     level, timeout_cycles, what);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic pulse_trigger();
        trg = 1'b1;
        @(posedge clk);
        #2;
        trg = 1'b0;
    endtask

    task automatic build_expected(input bit print_screen);
        lcd_cmd_pkg::lcd_byte_t line_start [4];
        expected.delete();
        if (!print_screen) begin
            expected.push_back({1'b0, 4'h0, lcd_cmd_pkg::inst_function_set[7:4]});
            expected.push_back({1'b0, lcd_cmd_pkg::inst_function_set});
            expected.push_back({1'b0, lcd_cmd_pkg::inst_display_control});
            expected.push_back({1'b0, lcd_cmd_pkg::inst_entry_mode});
            expected.push_back({1'b0, lcd_cmd_pkg::inst_display_clear});
        end else begin
            line_start[0] = lcd_cmd_pkg::inst_ddram_line0;
            line_start[1] = lcd_cmd_pkg::inst_ddram_line1;
            line_start[2] = lcd_cmd_pkg::inst_ddram_line2;
            line_start[3] = lcd_cmd_pkg::inst_ddram_line3;
            for (int line = 0; line < 4; line++) begin
                expected.push_back({1'b0, line_start[line]});
                for (int col = 0; col < chars_per_line; col++) begin
                    expected.push_back({1'b1, char_mem[line * 32 + col]});
                end
            end
        end
    endtask

    task automatic compare_writes(input string name, input int count);
        check_equal({name, " write count"}, count, writes.size());
        for (int i = 0; i < expected.size() && i < writes.size(); i++) begin
            check_equal($sformatf("%s write %0d", name, i), expected[i], writes[i]);
        end
        writes.delete();
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int errors_before;
        rst = 1'b0;
        trg = 1'b0;
        fill_memory();

        // Outputs during reset and right after it
        repeat (reset_cycles - 1) @(posedge clk);
        #2;
        check_equal("reset e", 0, e);
        check_equal("reset rs", 0, rs);
        check_equal("reset db", 0, db);
        check_equal("reset char_addr", 0, char_addr);
        check_equal("reset busy", 1, busy);
        @(posedge clk);
        #2;
        rst = 1'b1;
        @(posedge clk);
        #2;
        check_equal("after reset e", 0, e);
        check_equal("after reset rs", 0, rs);
        check_equal("after reset db", 0, db);
        check_equal("after reset char_addr", 0, char_addr);
        check_equal("after reset busy", 1, busy);
        if (error_count == 0) begin
            $display("test reset: passed");
        end else begin
            $display("test reset: failed");
            failed_tests++;
        end

        for (int t = 0; t < num_tests && !timed_out; t++) begin
            errors_before = error_count;
            if (trg_delay[t] == 0) begin
                build_expected(1'b0);
                wait_for_busy(1'b0, "waiting for the init");
            end else begin
                repeat (trg_delay[t]) @(posedge clk);
                #2;
                check_equal({test_name[t], " writes while idle"}, 0, writes.size());
                writes.delete();
                fill_memory();
                build_expected(1'b1);
                pulse_trigger();
                wait_for_busy(1'b1, "starting a print");
                if (extra_delay[t] != 0 && !timed_out) begin
                    // Second trigger lands in the middle of the print
                    repeat (extra_delay[t]) @(posedge clk);
                    #2;
                    pulse_trigger();
                end
                if (!timed_out) begin
                    wait_for_busy(1'b0, "printing the screen");
                end
            end
            compare_writes(test_name[t], write_count[t]);
            if (error_count == errors_before) begin
                $display("test %s: passed", test_name[t]);
            end else begin
                $display("test %s: failed", test_name[t]);
                failed_tests++;
            end
        end

        // Nothing may be written once the last print is done
        if (!timed_out) begin
            repeat (200) @(posedge clk);
            #2;
            check_equal("final writes while idle", 0, writes.size());
        end

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 num_tests + 1, failed_tests, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: bench/lcd_hd44780_props.sv
// Bus timing assertions for the nibble writer
// Attached to every lcd_nibble_writer instance through the bind below

module lcd_hd44780_props (
    input logic                     clk,
    input logic                     rst,
    input logic                     cmd_strobe,
    input logic                     writer_busy,
    input logic                     e,
    input logic                     rs,
    input lcd_cmd_pkg::lcd_nibble_t db
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int pulse_len = int'(lcd_timing_pkg::pulse_cycles);

    // Enable pulse width
    assert property (@(posedge clk) disable iff (!rst)
        $rose(e) |-> e [*pulse_len] ##1 !e)
        else $error("enable pulse is not %0d cycles wide", pulse_len);

    // Bus held while the display latches it
    assert property (@(posedge clk) disable iff (!rst)
        e && $past(e) |-> $stable(db) && $stable(rs))
        else $error("db or rs changed while enable was high");

    assert property (@(posedge clk) disable iff (!rst)
        e |-> writer_busy)
        else $error("enable high while the writer is not busy");

    // One command in flight
    assert property (@(posedge clk) disable iff (!rst)
        cmd_strobe |-> !writer_busy)
        else $error("command strobe while the writer is busy");

endmodule

bind lcd_nibble_writer lcd_hd44780_props lcd_hd44780_props_i (
    .clk         (clk),
    .rst         (rst),
    .cmd_strobe  (cmd_strobe),
    .writer_busy (writer_busy),
    .e           (e),
    .rs          (rs),
    .db          (db)
);

// File: rtl/lcd_hd44780_top.sv
// HD44780 controller in 4-bit mode for a 4x20 display
// Chains init sequencer, print sequencer and nibble writer

module lcd_hd44780_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     trg,
    input  lcd_cmd_pkg::lcd_byte_t   char_data,
    output logic                     busy,
    output logic                     e,
    output logic                     rs,
    output lcd_cmd_pkg::lcd_nibble_t db,
    output lcd_cmd_pkg::char_addr_t  char_addr
);

    // Init stage to print stage
    logic                   init_strobe;
    lcd_cmd_pkg::lcd_byte_t init_byte;
    logic                   init_single;
    logic                   init_done;

    // Print stage to writer
    logic                   cmd_strobe;
    lcd_cmd_pkg::lcd_byte_t cmd_byte;
    logic                   cmd_rs;
    logic                   cmd_single;
    logic                   cmd_long;
    logic                   writer_busy;

    lcd_init_sequencer lcd_init_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .writer_busy (writer_busy),
        .cmd_strobe  (init_strobe),
        .cmd_byte    (init_byte),
        .cmd_single  (init_single),
        .init_done   (init_done)
    );

    lcd_print_sequencer lcd_print_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .trg         (trg),
        .init_done   (init_done),
        .init_strobe (init_strobe),
        .init_byte   (init_byte),
        .init_single (init_single),
        .writer_busy (writer_busy),
        .char_data   (char_data),
        .busy        (busy),
        .char_addr   (char_addr),
        .cmd_strobe  (cmd_strobe),
        .cmd_byte    (cmd_byte),
        .cmd_rs      (cmd_rs),
        .cmd_single  (cmd_single),
        .cmd_long    (cmd_long)
    );

    lcd_nibble_writer lcd_nibble_writer_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_strobe  (cmd_strobe),
        .cmd_byte    (cmd_byte),
        .cmd_rs      (cmd_rs),
        .cmd_single  (cmd_single),
        .cmd_long    (cmd_long),
        .writer_busy (writer_busy),
        .e           (e),
        .rs          (rs),
        .db          (db)
    );

endmodule

// File: rtl/lcd_nibble_writer.sv
// Drives the 4-bit display bus for one command at a time
// High nibble, optional low nibble, then the settle wait before going idle

module lcd_nibble_writer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_strobe,
    input  lcd_cmd_pkg::lcd_byte_t   cmd_byte,
    input  logic                     cmd_rs,
    input  logic                     cmd_single,
    input  logic                     cmd_long,
    output logic                     writer_busy,
    output logic                     e,
    output logic                     rs,
    output lcd_cmd_pkg::lcd_nibble_t db
);

    lcd_cmd_pkg::writer_state_t state;
    lcd_timing_pkg::cnt_t       cnt;
    lcd_timing_pkg::cnt_t       wait_cycles;
    lcd_cmd_pkg::lcd_byte_t     byte_q;
    logic                       single_q;
    logic                       long_q;

    assign writer_busy = (state != lcd_cmd_pkg::wr_idle);

    assign wait_cycles = long_q ? lcd_timing_pkg::long_wait_cycles
                                : lcd_timing_pkg::short_wait_cycles;

    // Command byte, held for the low nibble
    always_ff @(posedge clk) begin
        if (cmd_strobe && !writer_busy) begin
            byte_q <= cmd_byte;
        end
    end

    // Counter starts at 1 so each phase lasts exactly its cycle count
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= lcd_cmd_pkg::wr_idle;
            cnt      <= '0;
            single_q <= 1'b0;
            long_q   <= 1'b0;
            e        <= 1'b0;
            rs       <= 1'b0;
            db       <= '0;
        end else begin
            cnt <= cnt + lcd_timing_pkg::cnt_t'(1);
            case (state)
                lcd_cmd_pkg::wr_idle: begin
                    if (cmd_strobe) begin
                        single_q <= cmd_single;
                        long_q   <= cmd_long;
                        rs       <= cmd_rs;
                        e        <= 1'b1;
                        db       <= cmd_byte[7:4];
                        cnt      <= lcd_timing_pkg::cnt_t'(1);
                        state    <= lcd_cmd_pkg::wr_high;
                    end
                end
                lcd_cmd_pkg::wr_high: begin
                    if (cnt == lcd_timing_pkg::pulse_cycles) begin
                        e   <= 1'b0;
                        cnt <= lcd_timing_pkg::cnt_t'(1);
                        if (single_q) begin
                            db    <= '0;
                            state <= lcd_cmd_pkg::wr_wait;
                        end else begin
                            state <= lcd_cmd_pkg::wr_gap;
                        end
                    end
                end
                lcd_cmd_pkg::wr_gap: begin
                    if (cnt == lcd_timing_pkg::nibble_gap_cycles) begin
                        e     <= 1'b1;
                        db    <= byte_q[3:0];
                        cnt   <= lcd_timing_pkg::cnt_t'(1);
                        state <= lcd_cmd_pkg::wr_low;
                    end
                end
                lcd_cmd_pkg::wr_low: begin
                    if (cnt == lcd_timing_pkg::pulse_cycles) begin
                        e     <= 1'b0;
                        db    <= '0;
                        cnt   <= lcd_timing_pkg::cnt_t'(1);
                        state <= lcd_cmd_pkg::wr_wait;
                    end
                end
                lcd_cmd_pkg::wr_wait: begin
                    // Display executes the command here
                    if (cnt == wait_cycles) begin
                        rs    <= 1'b0;
                        state <= lcd_cmd_pkg::wr_idle;
                    end
                end
                default: begin
                    state <= lcd_cmd_pkg::wr_idle;
                end
            endcase
        end
    end

endmodule

// File: rtl/lcd_print_sequencer.sv
// Print stage of the display controller
// Forwards init commands, then on trg writes all four lines from character memory

module lcd_print_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    trg,
    input  logic                    init_done,
    input  logic                    init_strobe,
    input  lcd_cmd_pkg::lcd_byte_t  init_byte,
    input  logic                    init_single,
    input  logic                    writer_busy,
    input  lcd_cmd_pkg::lcd_byte_t  char_data,
    output logic                    busy,
    output lcd_cmd_pkg::char_addr_t char_addr,
    output logic                    cmd_strobe,
    output lcd_cmd_pkg::lcd_byte_t  cmd_byte,
    output logic                    cmd_rs,
    output logic                    cmd_single,
    output logic                    cmd_long
);

    lcd_cmd_pkg::print_state_t state;
    lcd_cmd_pkg::line_t        line;
    lcd_cmd_pkg::col_t         col;
    lcd_cmd_pkg::lcd_byte_t    line_inst;
    logic                      ready;

    // Own strobe is not yet visible as writer_busy in the cycle it is high
    assign ready = !writer_busy && !cmd_strobe;

    // DDRAM start address of the current line
    always_comb begin
        case (line)
            2'd0:    line_inst = lcd_cmd_pkg::inst_ddram_line0;
            2'd1:    line_inst = lcd_cmd_pkg::inst_ddram_line1;
            2'd2:    line_inst = lcd_cmd_pkg::inst_ddram_line2;
            default: line_inst = lcd_cmd_pkg::inst_ddram_line3;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= lcd_cmd_pkg::print_idle;
            line       <= '0;
            col        <= '0;
            busy       <= 1'b1;
            char_addr  <= '0;
            cmd_strobe <= 1'b0;
            cmd_byte   <= '0;
            cmd_rs     <= 1'b0;
            cmd_single <= 1'b0;
            cmd_long   <= 1'b0;
        end else begin
            cmd_strobe <= 1'b0;
            case (state)
                lcd_cmd_pkg::print_idle: begin
                    if (!init_done) begin
                        // Init commands are always long-wait instructions
                        if (init_strobe) begin
                            cmd_strobe <= 1'b1;
                            cmd_byte   <= init_byte;
                            cmd_rs     <= 1'b0;
                            cmd_single <= init_single;
                            cmd_long   <= 1'b1;
                        end
                    end else if (trg) begin
                        busy  <= 1'b1;
                        line  <= '0;
                        state <= lcd_cmd_pkg::print_line;
                    end else begin
                        busy <= 1'b0;
                    end
                end
                lcd_cmd_pkg::print_line: begin
                    if (ready) begin
                        cmd_strobe <= 1'b1;
                        cmd_byte   <= line_inst;
                        cmd_rs     <= 1'b0;
                        cmd_single <= 1'b0;
                        cmd_long   <= 1'b1;
                        col        <= '0;
                        state      <= lcd_cmd_pkg::print_addr;
                    end
                end
                lcd_cmd_pkg::print_addr: begin
                    char_addr <= {line, col};
                    state     <= lcd_cmd_pkg::print_fetch;
                end
                // One cycle for a registered memory to answer
                lcd_cmd_pkg::print_fetch: begin
                    state <= lcd_cmd_pkg::print_char;
                end
                lcd_cmd_pkg::print_char: begin
                    if (ready) begin
                        cmd_strobe <= 1'b1;
                        cmd_byte   <= char_data;
                        cmd_rs     <= 1'b1;
                        cmd_single <= 1'b0;
                        cmd_long   <= 1'b0;
                        if (col == lcd_cmd_pkg::line_chars - lcd_cmd_pkg::col_t'(1)) begin
                            if (line == lcd_cmd_pkg::line_t'(3)) begin
                                state <= lcd_cmd_pkg::print_finish;
                            end else begin
                                line  <= line + lcd_cmd_pkg::line_t'(1);
                                state <= lcd_cmd_pkg::print_line;
                            end
                        end else begin
                            col   <= col + lcd_cmd_pkg::col_t'(1);
                            state <= lcd_cmd_pkg::print_addr;
                        end
                    end
                end
                lcd_cmd_pkg::print_finish: begin
                    // Last character and its wait are through the writer
                    if (ready) begin
                        busy  <= 1'b0;
                        state <= lcd_cmd_pkg::print_idle;
                    end
                end
                default: begin
                    state <= lcd_cmd_pkg::print_idle;
                end
            endcase
        end
    end

endmodule

// File: rtl/lcd_init_sequencer.sv
// Power-on initialization of the display
// Waits after reset, then issues the fixed instruction list one by one

module lcd_init_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  writer_busy,
    output logic                  cmd_strobe,
    output lcd_cmd_pkg::lcd_byte_t cmd_byte,
    output logic                  cmd_single,
    output logic                  init_done
);

    lcd_cmd_pkg::init_state_t state;
    lcd_timing_pkg::cnt_t     cnt;

    // Set with each strobe, cleared once the writer reports busy
    // The strobe reaches the writer through the print stage register
    logic pending;
    logic ready;

    assign ready = !pending && !writer_busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= lcd_cmd_pkg::init_poweron;
            cnt        <= '0;
            pending    <= 1'b0;
            cmd_strobe <= 1'b0;
            cmd_byte   <= '0;
            cmd_single <= 1'b0;
            init_done  <= 1'b0;
        end else begin
            cmd_strobe <= 1'b0;
            if (pending && writer_busy) begin
                pending <= 1'b0;
            end
            case (state)
                lcd_cmd_pkg::init_poweron: begin
                    cnt <= cnt + lcd_timing_pkg::cnt_t'(1);
                    // Single nibble function set wakes the controller into 4-bit mode
                    if (cnt == lcd_timing_pkg::poweron_cycles - lcd_timing_pkg::cnt_t'(1)) begin
                        cmd_strobe <= 1'b1;
                        cmd_byte   <= lcd_cmd_pkg::inst_function_set;
                        cmd_single <= 1'b1;
                        pending    <= 1'b1;
                        state      <= lcd_cmd_pkg::init_function_set;
                    end
                end
                lcd_cmd_pkg::init_function_set,
                lcd_cmd_pkg::init_display_control,
                lcd_cmd_pkg::init_entry_mode,
                lcd_cmd_pkg::init_display_clear: begin
                    if (ready) begin
                        cmd_strobe <= 1'b1;
                        cmd_single <= 1'b0;
                        pending    <= 1'b1;
                        case (state)
                            lcd_cmd_pkg::init_function_set: begin
                                cmd_byte <= lcd_cmd_pkg::inst_function_set;
                                state    <= lcd_cmd_pkg::init_display_control;
                            end
                            lcd_cmd_pkg::init_display_control: begin
                                cmd_byte <= lcd_cmd_pkg::inst_display_control;
                                state    <= lcd_cmd_pkg::init_entry_mode;
                            end
                            lcd_cmd_pkg::init_entry_mode: begin
                                cmd_byte <= lcd_cmd_pkg::inst_entry_mode;
                                state    <= lcd_cmd_pkg::init_display_clear;
                            end
                            default: begin
                                cmd_byte <= lcd_cmd_pkg::inst_display_clear;
                                state    <= lcd_cmd_pkg::init_finish;
                            end
                        endcase
                    end
                end
                lcd_cmd_pkg::init_finish: begin
                    // Clear and its wait are done
                    if (ready) begin
                        init_done <= 1'b1;
                        state     <= lcd_cmd_pkg::init_idle;
                    end
                end
                default: begin
                    state <= lcd_cmd_pkg::init_idle;
                end
            endcase
        end
    end

endmodule

// File: rtl/lcd_cmd_pkg.sv
// Instruction set, memory addressing and FSM state types for the display
// Shared by the sequencers, the nibble writer and the top level

package lcd_cmd_pkg;

    ////////////////////////////////////////
    // Bus and memory types
    ////////////////////////////////////////

    typedef logic [7:0] lcd_byte_t;
    typedef logic [3:0] lcd_nibble_t;

    // Memory address is line on top of column, 32 slots per line
    typedef logic [1:0] line_t;
    typedef logic [4:0] col_t;
    typedef logic [6:0] char_addr_t;

    // Visible characters per line
    localparam col_t line_chars = col_t'(20);

    ////////////////////////////////////////
    // Instructions
    ////////////////////////////////////////

    // 4-bit bus, two lines, 5x8 font
    localparam lcd_byte_t inst_function_set = 8'h28;
    // Display on, cursor on, no blink
    localparam lcd_byte_t inst_display_control = 8'h0E;
    // Increment with shift
    localparam lcd_byte_t inst_entry_mode = 8'h07;
    localparam lcd_byte_t inst_display_clear = 8'h01;

    // Set DDRAM address to the start of each line
    // Lines 2 and 3 continue lines 0 and 1 after 20 characters
    localparam lcd_byte_t inst_ddram_line0 = 8'h80;
    localparam lcd_byte_t inst_ddram_line1 = 8'hC0;
    localparam lcd_byte_t inst_ddram_line2 = 8'h94;
    localparam lcd_byte_t inst_ddram_line3 = 8'hD4;

    ////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        init_poweron, init_function_set, init_display_control,
        init_entry_mode, init_display_clear, init_finish, init_idle
    } init_state_t;

    typedef enum logic [2:0] {
        print_idle, print_line, print_addr, print_fetch, print_char, print_finish
    } print_state_t;

    typedef enum logic [2:0] {
        wr_idle, wr_high, wr_gap, wr_low, wr_wait
    } writer_state_t;

endpackage

// File: rtl/lcd_timing_pkg.sv
// Wait and pulse lengths for the HD44780 controller, in clock cycles
// Every counter in the design uses cnt_t and compares against these values

package lcd_timing_pkg;

    ////////////////////////////////////////
    // Clock and counter
    ////////////////////////////////////////

    // All counts below assume this clock
    localparam int clk_hz = 250_000;

    // Wide enough for the power-on wait
    localparam int cnt_width = 18;

    typedef logic [cnt_width-1:0] cnt_t;

    ////////////////////////////////////////
    // Display timing
    ////////////////////////////////////////

    // 100 ms before the first instruction
    localparam cnt_t poweron_cycles = cnt_t'(clk_hz / 10);

    // 10 ms after instructions, covers clear and return home
    localparam cnt_t long_wait_cycles = cnt_t'(clk_hz / 100);

    // 80 us after a character write
    localparam cnt_t short_wait_cycles = cnt_t'(clk_hz * 80 / 1_000_000);

    // Enable high time
    localparam cnt_t pulse_cycles = cnt_t'(10);

    // Enable low time between the two nibbles of a byte
    localparam cnt_t nibble_gap_cycles = cnt_t'(20);

endpackage
